// ==== rtl/dbg_trig_pkg.sv ====
package dbg_trig_pkg;

  ////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////

  typedef logic [31:0] xlen_t;            // Data and address word

  localparam int MAX_TRIGGERS = 4;        // Upper bound for NUM_TRIGGERS

  typedef enum logic [3:0] {
    TTYPE_MCONTROL6 = 4'h6,               // Address/data match trigger
    TTYPE_DISABLED  = 4'hF                // Trigger exists but is off
  } ttype_e;

  typedef enum logic [3:0] {
    MATCH_EQ = 4'h0,                      // Address equal to tdata2
    MATCH_GE = 4'h2,                      // Address at or above tdata2
    MATCH_LT = 4'h3                       // Address below tdata2
  } match_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  ////////////////////////////////////////
  // tdata1 layout
  ////////////////////////////////////////

  // Fields common to every trigger type
  typedef struct packed {
    ttype_e      ttype;                   // 31:28
    logic        dmode;                   // 27, D-mode only access
    logic [26:0] data;                    // Type specific part
  } tdata1_hdr_t;

  // Type 6 view
  typedef struct packed {
    ttype_e      ttype;                   // 31:28
    logic        dmode;                   // 27
    logic [10:0] zero_hi;                 // 26:16, uncertain/hit/vs/vu/select/size
    logic [3:0]  action;                  // 15:12
    logic        chain;                   // 11
    match_e      match;                   // 10:7
    logic        m;                       // 6
    logic        zero_lo;                 // 5, uncertainen
    logic        s;                       // 4
    logic        u;                       // 3
    logic        execute;                 // 2
    logic        store;                   // 1
    logic        load;                    // 0
  } mcontrol6_t;

  typedef union packed {
    tdata1_hdr_t hdr;
    mcontrol6_t  mc6;
  } tdata1_u;

  localparam xlen_t      TDATA1_RST_VAL     = 32'hF800_0000; // Disabled, dmode set
  localparam logic [3:0] ACTION_ENTER_DEBUG = 4'h1;

  ////////////////////////////////////////
  // Port bundles
  ////////////////////////////////////////

  typedef struct packed {
    xlen_t wdata;                         // Shared CSR write data
    logic  tselect_we;
    logic  tdata1_we;
    logic  tdata2_we;
  } csr_wr_t;

  typedef struct packed {
    xlen_t   tselect;
    tdata1_u tdata1;                      // Selected trigger
    xlen_t   tdata2;
  } csr_rd_t;

  typedef struct packed {
    xlen_t pc;                            // Fetch PC in IF
    priv_e priv;
  } if_req_t;

  typedef struct packed {
    logic       valid;
    xlen_t      addr;                     // Byte address of the access
    logic       we;                       // Store when set
    logic [3:0] be;                       // Byte enables within the word
    priv_e      priv;
  } lsu_req_t;

endpackage

// ==== rtl/dbg_trig_csr_decode.sv ====
`timescale 1ns/1ns

module dbg_trig_csr_decode
  import dbg_trig_pkg::*;
#(
  parameter int NUM_TRIGGERS = 2
) (
  input  csr_wr_t                 csr_wr_i,
  input  xlen_t                   tselect_q_i,     // Currently selected trigger
  output logic                    tselect_we_o,
  output tdata1_u                 tdata1_next_o,   // WARL-resolved tdata1
  output logic [NUM_TRIGGERS-1:0] tdata1_we_o,
  output logic [NUM_TRIGGERS-1:0] tdata2_we_o
);

  tdata1_u    wr_view;                             // Raw write data seen as tdata1
  mcontrol6_t mc6_next;
  logic       match_legal;

  assign wr_view = csr_wr_i.wdata;

  ////////////////////////////////////////
  // tdata1 WARL
  ////////////////////////////////////////

  // Only 0, 2 and 3 are implemented match codes
  assign match_legal = (wr_view.mc6.match == MATCH_EQ) ||
                       (wr_view.mc6.match == MATCH_GE) ||
                       (wr_view.mc6.match == MATCH_LT);

  always_comb begin
    mc6_next         = '0;                         // Unsupported fields read as zero
    mc6_next.ttype   = TTYPE_MCONTROL6;
    mc6_next.dmode   = 1'b1;                       // Writable from debug mode only
    mc6_next.action  = ACTION_ENTER_DEBUG;
    mc6_next.match   = match_legal ? wr_view.mc6.match : MATCH_EQ;
    mc6_next.m       = wr_view.mc6.m;
    mc6_next.u       = wr_view.mc6.u;
    mc6_next.execute = wr_view.mc6.execute;
    mc6_next.store   = wr_view.mc6.store;
    mc6_next.load    = wr_view.mc6.load;
  end

  always_comb begin
    if (wr_view.hdr.ttype == TTYPE_MCONTROL6) begin
      tdata1_next_o.mc6 = mc6_next;
    end else begin
      tdata1_next_o = TDATA1_RST_VAL;              // Any other type disables the trigger
    end
  end

  ////////////////////////////////////////
  // Write strobes
  ////////////////////////////////////////

  // tselect WARL, out-of-range values are dropped
  assign tselect_we_o = csr_wr_i.tselect_we && (csr_wr_i.wdata < xlen_t'(NUM_TRIGGERS));

  // Route tdata strobes to the selected trigger only
  always_comb begin
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      tdata1_we_o[i] = csr_wr_i.tdata1_we && (tselect_q_i == xlen_t'(i));
      tdata2_we_o[i] = csr_wr_i.tdata2_we && (tselect_q_i == xlen_t'(i));
    end
  end

endmodule

// ==== rtl/dbg_trig_csr_bank.sv ====
`timescale 1ns/1ns

module dbg_trig_csr_bank
  import dbg_trig_pkg::*;
#(
  parameter int NUM_TRIGGERS = 2
) (
  input  logic                    clk,
  input  logic                    reset_i,
  input  xlen_t                   wdata_i,          // tselect and tdata2 data
  input  logic                    tselect_we_i,     // Already range checked
  input  tdata1_u                 tdata1_next_i,
  input  logic [NUM_TRIGGERS-1:0] tdata1_we_i,
  input  logic [NUM_TRIGGERS-1:0] tdata2_we_i,
  output csr_rd_t                 csr_rd_o,
  output tdata1_u                 tdata1_q_o [NUM_TRIGGERS],
  output xlen_t                   tdata2_q_o [NUM_TRIGGERS]
);

  localparam int SEL_W = $clog2(MAX_TRIGGERS);      // Enough for any legal index

  logic [SEL_W-1:0] tselect_q;

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      tselect_q <= '0;
    end else if (tselect_we_i) begin
      tselect_q <= wdata_i[SEL_W-1:0];               // Upper bits are zero here
    end
  end

  for (genvar t = 0; t < NUM_TRIGGERS; t++) begin : g_trig_regs
    always_ff @(posedge clk) begin
      if (reset_i) begin
        tdata1_q_o[t] <= TDATA1_RST_VAL;             // Start disabled
        tdata2_q_o[t] <= '0;
      end else begin
        if (tdata1_we_i[t]) begin
          tdata1_q_o[t] <= tdata1_next_i;
        end
        if (tdata2_we_i[t]) begin
          tdata2_q_o[t] <= wdata_i;                  // Any value is legal for type 6
        end
      end
    end
  end

  ////////////////////////////////////////
  // Readback
  ////////////////////////////////////////

  always_comb begin
    csr_rd_o.tselect = xlen_t'(tselect_q);
    csr_rd_o.tdata1  = tdata1_q_o[0];
    csr_rd_o.tdata2  = tdata2_q_o[0];
    // Pick the selected pair
    for (int i = 0; i < NUM_TRIGGERS; i++) begin
      if (tselect_q == SEL_W'(i)) begin
        csr_rd_o.tdata1 = tdata1_q_o[i];
        csr_rd_o.tdata2 = tdata2_q_o[i];
      end
    end
  end

endmodule

// ==== rtl/dbg_trig_match.sv ====
`timescale 1ns/1ns

module dbg_trig_match
  import dbg_trig_pkg::*;
(
  input  tdata1_u  tdata1_i,
  input  xlen_t    tdata2_i,
  input  if_req_t  if_req_i,
  input  lsu_req_t lsu_req_i,
  input  logic     debug_mode_i,
  output logic     match_if_o,                       // Fetch address hit
  output logic     match_ex_o                        // Load/store address hit
);

  logic       is_mc6;
  mcontrol6_t mc6;
  logic       if_addr_hit;
  logic       if_priv_ok;
  logic       ex_priv_ok;
  logic       ex_en;
  logic       ex_addr_hit;
  logic [1:0] low_lsb;                               // Lowest enabled byte
  logic [1:0] high_lsb;                              // Highest enabled byte
  xlen_t      addr_low;
  xlen_t      addr_high;
  logic [3:0] byte_hit;

  // Type check through the header view, fields through the type 6 view
  assign is_mc6 = (tdata1_i.hdr.ttype == TTYPE_MCONTROL6);
  assign mc6    = tdata1_i.mc6;

  ////////////////////////////////////////
  // IF compare
  ////////////////////////////////////////

  always_comb begin
    case (mc6.match)
      MATCH_EQ: if_addr_hit = (if_req_i.pc == tdata2_i);
      MATCH_GE: if_addr_hit = (if_req_i.pc >= tdata2_i);
      default:  if_addr_hit = (if_req_i.pc <  tdata2_i);
    endcase
  end

  assign if_priv_ok = (mc6.m && (if_req_i.priv == PRIV_M)) ||
                      (mc6.u && (if_req_i.priv == PRIV_U));

  assign match_if_o = is_mc6 && mc6.execute && if_priv_ok && if_addr_hit && !debug_mode_i;

  ////////////////////////////////////////
  // EX compare
  ////////////////////////////////////////

  // Byte span of the access from be
  always_comb begin
    low_lsb  = 2'd0;
    high_lsb = 2'd0;
    for (int b = 3; b >= 0; b--) begin
      if (lsu_req_i.be[b]) low_lsb = 2'(b);          // Last hit wins, lowest
    end
    for (int b = 0; b < 4; b++) begin
      if (lsu_req_i.be[b]) high_lsb = 2'(b);         // Last hit wins, highest
      byte_hit[b] = lsu_req_i.be[b] && (tdata2_i[1:0] == 2'(b));
    end
  end

  assign addr_low  = {lsu_req_i.addr[31:2], low_lsb};
  assign addr_high = {lsu_req_i.addr[31:2], high_lsb};

  always_comb begin
    case (mc6.match)
      // Same word and one of the enabled bytes is the target
      MATCH_EQ: ex_addr_hit = (lsu_req_i.addr[31:2] == tdata2_i[31:2]) && (|byte_hit);
      MATCH_GE: ex_addr_hit = (addr_high >= tdata2_i);
      default:  ex_addr_hit = (addr_low  <  tdata2_i);
    endcase
  end

  assign ex_priv_ok = (mc6.m && (lsu_req_i.priv == PRIV_M)) ||
                      (mc6.u && (lsu_req_i.priv == PRIV_U));

  // Load or store bit chosen by direction
  assign ex_en = lsu_req_i.valid &&
                 ((mc6.load && !lsu_req_i.we) || (mc6.store && lsu_req_i.we));

  assign match_ex_o = is_mc6 && ex_en && ex_priv_ok && ex_addr_hit && !debug_mode_i;

endmodule

// ==== rtl/dbg_triggers.sv ====
`timescale 1ns/1ns

module dbg_triggers
  import dbg_trig_pkg::*;
#(
  parameter int NUM_TRIGGERS = 2                     // 1 to MAX_TRIGGERS
) (
  input  logic                    clk,
  input  logic                    reset_i,
  input  csr_wr_t                 csr_wr_i,
  output csr_rd_t                 csr_rd_o,
  input  if_req_t                 if_req_i,
  input  lsu_req_t                lsu_req_i,
  input  logic                    debug_mode_i,      // Masks all matches
  output logic [NUM_TRIGGERS-1:0] trigger_match_if_o,
  output logic [NUM_TRIGGERS-1:0] trigger_match_ex_o
);

  logic                    tselect_we;
  tdata1_u                 tdata1_next;
  logic [NUM_TRIGGERS-1:0] tdata1_we;
  logic [NUM_TRIGGERS-1:0] tdata2_we;
  tdata1_u                 tdata1_q [NUM_TRIGGERS];
  xlen_t                   tdata2_q [NUM_TRIGGERS];

  // WARL and strobe routing
  dbg_trig_csr_decode #(.NUM_TRIGGERS(NUM_TRIGGERS)) i_decode (
    .csr_wr_i      (csr_wr_i),
    .tselect_q_i   (csr_rd_o.tselect),
    .tselect_we_o  (tselect_we),
    .tdata1_next_o (tdata1_next),
    .tdata1_we_o   (tdata1_we),
    .tdata2_we_o   (tdata2_we)
  );

  // Trigger CSR state
  dbg_trig_csr_bank #(.NUM_TRIGGERS(NUM_TRIGGERS)) i_bank (
    .clk           (clk),
    .reset_i       (reset_i),
    .wdata_i       (csr_wr_i.wdata),
    .tselect_we_i  (tselect_we),
    .tdata1_next_i (tdata1_next),
    .tdata1_we_i   (tdata1_we),
    .tdata2_we_i   (tdata2_we),
    .csr_rd_o      (csr_rd_o),
    .tdata1_q_o    (tdata1_q),
    .tdata2_q_o    (tdata2_q)
  );

  // One compare unit per trigger
  for (genvar t = 0; t < NUM_TRIGGERS; t++) begin : g_match
    dbg_trig_match i_match (
      .tdata1_i     (tdata1_q[t]),
      .tdata2_i     (tdata2_q[t]),
      .if_req_i     (if_req_i),
      .lsu_req_i    (lsu_req_i),
      .debug_mode_i (debug_mode_i),
      .match_if_o   (trigger_match_if_o[t]),
      .match_ex_o   (trigger_match_ex_o[t])
    );
  end

endmodule

// ==== include/tb_dbg_trig_ref.svh ====
`ifndef TB_DBG_TRIG_REF_SVH
`define TB_DBG_TRIG_REF_SVH

////////////////////////////////////////
// Trigger state model
////////////////////////////////////////

int    model_tsel;                                // Selected trigger index
xlen_t model_t1 [MAX_TRIGGERS];                   // tdata1 per trigger
xlen_t model_t2 [MAX_TRIGGERS];                   // tdata2 per trigger

// tdata1 value after WARL, built bit by bit from the mcontrol6 rules
function automatic xlen_t ref_tdata1_warl(input xlen_t w);
  xlen_t      r;
  logic [3:0] code;
  if (w[31:28] != 4'h6) begin
    return TDATA1_RST_VAL;                        // Any other type means disabled
  end
  code = w[10:7];
  if (code != 4'h0 && code != 4'h2 && code != 4'h3) begin
    code = 4'h0;                                  // Unsupported mode reads as equal
  end
  r       = 32'h6800_1000;                        // Type 6, dmode, action 1
  r[10:7] = code;
  r[6]    = w[6];                                 // m
  r[3]    = w[3];                                 // u
  r[2:0]  = w[2:0];                               // execute, store, load
  return r;
endfunction

// Fetch hit for one trigger
function automatic logic ref_if_match(input xlen_t t1, input xlen_t t2,
                                      input if_req_t req, input logic dbg);
  logic priv_ok;
  logic hit;
  priv_ok = (req.priv == PRIV_M) ? t1[6] : ((req.priv == PRIV_U) ? t1[3] : 1'b0);
  case (t1[10:7])
    4'h2:    hit = (req.pc >= t2);
    4'h3:    hit = (req.pc < t2);
    default: hit = (req.pc == t2);
  endcase
  return (t1[31:28] == 4'h6) && t1[2] && priv_ok && hit && !dbg;
endfunction

// Load/store hit for one trigger
function automatic logic ref_ex_match(input xlen_t t1, input xlen_t t2,
                                      input lsu_req_t req, input logic dbg);
  xlen_t base;
  xlen_t lo;
  xlen_t hi;
  logic  eq_hit;
  logic  priv_ok;
  logic  hit;
  base   = req.addr & 32'hFFFF_FFFC;
  lo     = base;                                  // No enabled byte gives the word base
  hi     = base;
  eq_hit = 1'b0;
  for (int b = 0; b < 4; b++) begin
    if (req.be[b]) begin
      hi = base + xlen_t'(b);                     // Ascending, so ends on the highest
      if (hi == t2) eq_hit = 1'b1;                // Some accessed byte is the target
    end
    if (req.be[3 - b]) lo = base + xlen_t'(3 - b);  // Descending, ends on the lowest
  end
  priv_ok = (req.priv == PRIV_M) ? t1[6] : ((req.priv == PRIV_U) ? t1[3] : 1'b0);
  case (t1[10:7])
    4'h2:    hit = (hi >= t2);
    4'h3:    hit = (lo < t2);
    default: hit = eq_hit;
  endcase
  return (t1[31:28] == 4'h6) && req.valid && (req.we ? t1[1] : t1[0]) &&
         priv_ok && hit && !dbg;
endfunction

function automatic void model_reset();
  model_tsel = 0;
  for (int t = 0; t < MAX_TRIGGERS; t++) begin
    model_t1[t] = TDATA1_RST_VAL;
    model_t2[t] = '0;
  end
endfunction

// Apply one CSR write, tdata strobes use the old tselect
function automatic void model_write(input csr_wr_t w, input int n_trig);
  if (w.tdata1_we) model_t1[model_tsel] = ref_tdata1_warl(w.wdata);
  if (w.tdata2_we) model_t2[model_tsel] = w.wdata;
  if (w.tselect_we && (w.wdata < xlen_t'(n_trig))) model_tsel = int'(w.wdata);
endfunction

function automatic csr_rd_t model_readback();
  csr_rd_t r;
  r.tselect = xlen_t'(model_tsel);
  r.tdata1  = model_t1[model_tsel];
  r.tdata2  = model_t2[model_tsel];
  return r;
endfunction

`endif

// ==== bench/tb_dbg_triggers.sv ====
`timescale 1ns/1ns

module tb_dbg_triggers
  import dbg_trig_pkg::*;
;

  localparam int         NUM_TRIG = 2;
  localparam int         ROUNDS   = 10;              // Config rounds per match test
  localparam int         RUN_LEN  = 24;              // Random input cycles per round
  localparam logic [2:0] WR_SEL   = 3'b100;          // Strobes as tselect, tdata1, tdata2
  localparam logic [2:0] WR_T1    = 3'b010;
  localparam logic [2:0] WR_T2    = 3'b001;
  // Reset, readback tests and two match tests at two cycles per write
  localparam int TEST_LEN   = 8 + 4 + 2 * 201 + 2 * 8 + 2 * ROUNDS * (6 * NUM_TRIG + RUN_LEN + 1);
  localparam int MAX_CYCLES = 2 * TEST_LEN;

  logic                clk;
  logic                reset_i;
  csr_wr_t             csr_wr;
  csr_rd_t             csr_rd;
  if_req_t             if_req;
  lsu_req_t            lsu_req;
  logic                debug_mode;
  logic [NUM_TRIG-1:0] match_if;
  logic [NUM_TRIG-1:0] match_ex;
  logic                rd_chk_en;                   // Readback agrees with the model
  logic                match_chk_en;
  logic                hold_chk_en;                 // Readback must equal saved_rd
  csr_rd_t             saved_rd;
  int                  err_count;
  int                  chk_count;
  int                  errs_at_start;
  int                  tests_run;
  int                  tests_failed;
  int                  cycles = 0;

  `include "tb_dbg_trig_ref.svh"

  dbg_triggers #(.NUM_TRIGGERS(NUM_TRIG)) i_dut (
    .clk                (clk),
    .reset_i            (reset_i),
    .csr_wr_i           (csr_wr),
    .csr_rd_o           (csr_rd),
    .if_req_i           (if_req),
    .lsu_req_i          (lsu_req),
    .debug_mode_i       (debug_mode),
    .trigger_match_if_o (match_if),
    .trigger_match_ex_o (match_ex)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                         // 20 ns period
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_csr_rd(input csr_rd_t got, input csr_rd_t exp);
    chk_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %0t ns: csr_rd tselect %0h/%0h tdata1 %h/%h tdata2 %h/%h (got/exp)",
               $time, got.tselect, exp.tselect, got.tdata1, exp.tdata1, got.tdata2, exp.tdata2);
    end
  endtask

  task automatic check_match(input logic [NUM_TRIG-1:0] got, input logic [NUM_TRIG-1:0] exp,
                             input string kind);
    chk_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %0t ns: %s match got %b exp %b", $time, kind, got, exp);
    end
  endtask

  // Falling edge, away from the input updates
  always @(negedge clk) begin
    logic [NUM_TRIG-1:0] exp_if;
    logic [NUM_TRIG-1:0] exp_ex;
    for (int t = 0; t < NUM_TRIG; t++) begin
      exp_if[t] = ref_if_match(model_t1[t], model_t2[t], if_req, debug_mode);
      exp_ex[t] = ref_ex_match(model_t1[t], model_t2[t], lsu_req, debug_mode);
    end
    if (rd_chk_en) check_csr_rd(csr_rd, model_readback());
    if (hold_chk_en) check_csr_rd(csr_rd, saved_rd);
    if (match_chk_en) begin
      check_match(match_if, exp_if, "IF");
      check_match(match_ex, exp_ex, "EX");
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Strobe for one cycle, readback is due in the next
  task automatic csr_write(input logic [2:0] strobes, input xlen_t data);
    csr_wr_t w;
    w = {data, strobes};
    @(posedge clk);
    csr_wr       <= w;
    rd_chk_en    <= 1'b0;                           // DUT lags the model here
    match_chk_en <= 1'b0;
    model_write(w, NUM_TRIG);
    @(posedge clk);
    csr_wr    <= '0;
    rd_chk_en <= 1'b1;
  endtask

  task automatic config_trigger(input int t, input logic ex_focus);
    xlen_t t1;
    t1       = $urandom;
    t1[10:7] = 4'($urandom % 4);                    // Code 1 resolves to equal
    if ($urandom % 8 != 0) t1[31:28] = 4'h6;        // Some triggers stay disabled
    if (ex_focus) t1[0] = 1'b1;                     // Keep the path under test enabled
    else t1[2] = 1'b1;
    csr_write(WR_SEL, xlen_t'(t));
    csr_write(WR_T1, t1);
    csr_write(WR_T2, $urandom);
  endtask

  task automatic drive_random_inputs();
    xlen_t near;
    near = model_t2[$urandom % NUM_TRIG];           // Addresses around a live tdata2
    @(posedge clk);
    if_req.pc     <= ($urandom % 4 == 0) ? $urandom : near;
    if_req.priv   <= ($urandom % 2 == 0) ? PRIV_U : PRIV_M;
    lsu_req.valid <= ($urandom % 4 != 0);
    lsu_req.addr  <= near + ($urandom % 8) - 32'd4;
    lsu_req.we    <= 1'($urandom);
    lsu_req.be    <= 4'($urandom);                  // Zero and partial enables too
    lsu_req.priv  <= ($urandom % 2 == 0) ? PRIV_U : PRIV_M;
    debug_mode    <= ($urandom % 8 == 0);
    match_chk_en  <= 1'b1;
  endtask

  task automatic run_match_test(input logic ex_focus);
    repeat (ROUNDS) begin
      for (int t = 0; t < NUM_TRIG; t++) config_trigger(t, ex_focus);
      repeat (RUN_LEN) drive_random_inputs();
    end
  endtask

  task automatic end_test(input string name);
    @(posedge clk);                                 // Let the last compare run
    tests_run++;
    if (err_count == errs_at_start) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name,
               err_count - errs_at_start);
    end
    errs_at_start = err_count;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    xlen_t val;
    void'($urandom(21252));
    reset_i      = 1'b1;
    csr_wr       = '0;
    if_req       = '0;
    lsu_req      = '0;
    debug_mode   = 1'b0;
    rd_chk_en    = 1'b0;
    match_chk_en = 1'b0;
    hold_chk_en  = 1'b0;
    saved_rd     = '0;
    err_count    = 0;
    chk_count    = 0;
    errs_at_start = 0;
    tests_run    = 0;
    tests_failed = 0;
    model_reset();
    repeat (8) @(posedge clk);
    reset_i <= 1'b0;

    @(posedge clk);
    rd_chk_en    <= 1'b1;                           // Reset values, triggers disabled
    match_chk_en <= 1'b1;
    repeat (2) @(posedge clk);
    end_test("reset values");

    for (int i = 0; i < 200; i++) begin
      if (i == 100) csr_write(WR_SEL, 32'd1);       // Second half on trigger 1
      val = $urandom;
      if ($urandom % 4 != 0) val[31:28] = 4'h6;     // Mostly type 6
      csr_write(WR_T1, val);
    end
    end_test("tdata1 WARL");

    csr_write(WR_SEL, 32'd0);
    saved_rd = model_readback();
    csr_write(WR_SEL, xlen_t'(NUM_TRIG) + $urandom % 16);  // Out of range, ignored
    csr_write(WR_SEL, 32'hFFFF_FFFF);
    csr_write(WR_SEL, 32'd1);
    csr_write(WR_T1, 32'h6000_0044);
    csr_write(WR_T2, $urandom);
    csr_write(WR_SEL, 32'd0);
    hold_chk_en <= 1'b1;                            // Trigger 0 as before
    end_test("tselect range and isolation");
    hold_chk_en <= 1'b0;

    run_match_test(1'b0);
    end_test("IF match");
    run_match_test(1'b1);
    end_test("EX match");

    $display("Summary: %0d tests, %0d failed, %0d compares, %0d errors",
             tests_run, tests_failed, chk_count, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
rtl/dbg_trig_pkg.sv
rtl/dbg_trig_csr_decode.sv
rtl/dbg_trig_csr_bank.sv
rtl/dbg_trig_match.sv
rtl/dbg_triggers.sv
bench/tb_dbg_triggers.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the trigger bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dbg_triggers -f src.f -o sim_dbg_triggers \
  || { echo "Build failed"; exit 1; }

out=$(./obj_dir/sim_dbg_triggers)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED" && exit 0 || exit 1
